// ==== rv_int_pipe.f ====
+incdir+verilog
+incdir+tests
verilog/rv_int_pipe_pkg.sv
verilog/insn_decoder.sv
verilog/stage_fifo.sv
verilog/alu_exec.sv
verilog/retire_port.sv
verilog/rv_int_pipe.sv
tests/tb_rv_int_pipe.sv

// ==== tests/tb_ref_model.svh ====
//////////////////////////////
// reference model for the
// integer datapath testbench
//////////////////////////////

`ifndef TB_REF_MODEL_SVH
`define TB_REF_MODEL_SVH

// model register file, x0 kept at zero by read_model_reg
logic [63:0] ref_regs [0:31];

function automatic logic [63:0] read_model_reg(input logic [4:0] idx);
    if (idx == 5'd0) begin
        return 64'd0;
    end
    return ref_regs[idx];
endfunction

// value written to rd by a kept instruction
function automatic logic [63:0] predict_value(input logic [31:0] insn);
    logic [63:0] a;
    logic [63:0] b;
    logic [5:0]  sh;
    logic        is_reg;
    is_reg = (insn[6:0] == `OP_ALRR);
    if (insn[6:0] == `OP_LUI) begin
        return {{32{insn[31]}}, insn[31:12], 12'd0};
    end
    a  = read_model_reg(insn[19:15]);
    b  = is_reg ? read_model_reg(insn[24:20]) : {{52{insn[31]}}, insn[31:20]};
    sh = b[5:0];
    case (insn[14:12])
        3'b000:  return (is_reg && insn[30]) ? a - b : a + b;
        3'b001:  return a << sh;
        3'b010:  return ($signed(a) < $signed(b)) ? 64'd1 : 64'd0;
        3'b011:  return (a < b) ? 64'd1 : 64'd0;
        3'b100:  return a ^ b;
        3'b101:  return insn[30] ? 64'($signed(a) >>> sh) : a >> sh;
        3'b110:  return a | b;
        default: return a & b;
    endcase
endfunction

`endif

// ==== tests/tb_rv_int_pipe.sv ====
//////////////////////////////
// testbench for rv_int_pipe
// random instruction stream
// checked against a model
//////////////////////////////

`timescale 1ns/1ps
`default_nettype none

`include "rv_int_pipe_consts.svh"

module tb_rv_int_pipe;

    localparam int N_INSN = 400;

    logic                   c_clk;
    logic                   c_rst_n;
    logic                   ins_req_i;
    logic [`ILEN-1:0]       ins_data_i;
    logic                   ins_ack_o;
    logic                   wb_req_o;
    logic [`REG_ADDR_W-1:0] wb_rd_o;
    logic [`XLEN-1:0]       wb_data_o;
    logic                   wb_ack_i;

    logic [31:0]                lfsr_state;
    rv_int_pipe_pkg::retire_t   exp_q [$];
    int                         delay_q [$];
    int                         rec_count;

    `include "tb_ref_model.svh"

    rv_int_pipe uut (
        .c_clk      (c_clk      ),
        .c_rst_n    (c_rst_n    ),
        .ins_req_i  (ins_req_i  ),
        .ins_data_i (ins_data_i ),
        .ins_ack_o  (ins_ack_o  ),
        .wb_req_o   (wb_req_o   ),
        .wb_rd_o    (wb_rd_o    ),
        .wb_data_o  (wb_data_o  ),
        .wb_ack_i   (wb_ack_i   )
    );

    always #2 c_clk = ~c_clk;

    // galois LFSR, one step per bit
    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            v = {v[30:0], lfsr_state[0]};
            lfsr_state = lfsr_state[0] ? (lfsr_state >> 1) ^ 32'hA300_0000 : lfsr_state >> 1;
        end
        return v;
    endfunction

    function automatic logic [31:0] make_insn();
        logic [2:0]  kind;
        logic [2:0]  f3;
        logic [4:0]  rd;
        logic [4:0]  rs1;
        logic [4:0]  rs2;
        logic [11:0] imm;
        logic        alt;
        kind = 3'(rand_bits(3));
        f3   = 3'(rand_bits(3));
        // mostly low registers, so ops depend on each other
        rd   = rand_bits(1) ? 5'(rand_bits(5)) : 5'(rand_bits(3));
        rs1  = rand_bits(1) ? 5'(rand_bits(5)) : 5'(rand_bits(3));
        rs2  = 5'(rand_bits(3));
        imm  = 12'(rand_bits(12));
        alt  = 1'(rand_bits(1));
        if (kind <= 3'd2) begin
            if (f3 == 3'b001) imm = {6'd0, imm[5:0]};
            if (f3 == 3'b101) imm = {1'b0, alt, 4'd0, imm[5:0]};
            return {imm, rs1, f3, rd, `OP_ALRI};
        end else if (kind <= 3'd5) begin
            alt = alt && (f3 == 3'b000 || f3 == 3'b101);
            return {1'b0, alt, 5'd0, rs2, rs1, f3, rd, `OP_ALRR};
        end else if (kind == 3'd6) begin
            return {imm, rs1[2:0], rs2, rd, `OP_LUI};
        end
        // load opcode stands in for everything unsupported
        return {imm, rs1, f3, rd, 7'b0000011};
    endfunction

    task automatic fail_now(input string msg);
        $display("%s", msg);
        $display("ERRORS FOUND");
        $fatal(1);
    endtask

    a_ack_falls_after_req: assert property (@(posedge c_clk) disable iff (!c_rst_n)
        $fell(ins_ack_o) |-> !$past(ins_req_i))
        else fail_now("ins_ack_o dropped while ins_req_i was still high");
    a_wb_req_waits_ack_low: assert property (@(posedge c_clk) disable iff (!c_rst_n)
        $rose(wb_req_o) |-> !wb_ack_i)
        else fail_now("wb_req_o rose before wb_ack_i had fallen");
    a_wb_data_stable: assert property (@(posedge c_clk) disable iff (!c_rst_n)
        wb_req_o && !wb_ack_i |=> $stable(wb_data_o) && $stable(wb_rd_o))
        else fail_now("wb_data_o or wb_rd_o changed while wb_req_o was high");

    initial begin
        #(N_INSN * 40 * 4);
        fail_now("timeout: the run did not complete in the expected time");
    end

    // outbound receiver with random ack delay
    initial begin
        rv_int_pipe_pkg::retire_t exp;
        int                       delay;
        wait (c_rst_n === 1'b1);
        forever begin
            do @(posedge c_clk); while (!wb_req_o);
            if (exp_q.size() == 0) fail_now("retire record arrived with none expected");
            exp   = exp_q.pop_front();
            delay = delay_q.pop_front();
            if (rec_count >= 100 && rec_count < 200) delay = delay * 5;
            repeat (delay) @(posedge c_clk);
            assert (wb_rd_o == exp.rd)
                else fail_now($sformatf("error wb_rd_o got %h expected %h", wb_rd_o, exp.rd));
            assert (wb_data_o == exp.data)
                else fail_now($sformatf("error wb_data_o got %h expected %h",
                                        wb_data_o, exp.data));
            rec_count = rec_count + 1;
            wb_ack_i <= 1'b1;
            do @(posedge c_clk); while (wb_req_o);
            wb_ack_i <= 1'b0;
        end
    end

    // reset, inbound sender and end of run
    initial begin
        logic [31:0]              insn;
        rv_int_pipe_pkg::retire_t rec;
        c_clk      = 1'b0;
        c_rst_n    = 1'b0;
        ins_req_i  = 1'b0;
        ins_data_i = '0;
        wb_ack_i   = 1'b0;
        lfsr_state = 32'd2479;
        rec_count  = 0;
        for (int i = 0; i < 32; i++) ref_regs[i] = '0;
        repeat (3) @(posedge c_clk);
        c_rst_n <= 1'b1;
        repeat (2) @(posedge c_clk);
        assert (!ins_ack_o && !wb_req_o)
            else fail_now($sformatf("error ins_ack_o %h wb_req_o %h after reset",
                                    ins_ack_o, wb_req_o));
        for (int n = 0; n < N_INSN; n++) begin
            insn = make_insn();
            if (insn[6:0] == `OP_ALRI || insn[6:0] == `OP_ALRR || insn[6:0] == `OP_LUI) begin
                rec.rd   = insn[11:7];
                rec.data = (insn[11:7] == 5'd0) ? 64'd0 : predict_value(insn);
                if (insn[11:7] != 5'd0) ref_regs[insn[11:7]] = rec.data;
                exp_q.push_back(rec);
                delay_q.push_back(int'(rand_bits(3)));
            end
            ins_req_i  <= 1'b1;
            ins_data_i <= insn;
            do @(posedge c_clk); while (!ins_ack_o);
            ins_req_i <= 1'b0;
            do @(posedge c_clk); while (ins_ack_o);
        end
        wait (exp_q.size() == 0);
        // stray records would show up here
        repeat (50) @(posedge c_clk);
        $display("NO ERRORS");
        $finish;
    end

endmodule

`default_nettype wire

// ==== verilog/rv_int_pipe.sv ====
//////////////////////////////
// rv_int_pipe
// RV64 integer datapath from
// insn handshake to retire
//////////////////////////////

`timescale 1ns/1ps
`default_nettype none

`include "rv_int_pipe_consts.svh"

module rv_int_pipe (
    input  wire                    c_clk,
    input  wire                    c_rst_n,
    input  wire                    ins_req_i,
    input  wire [`ILEN-1:0]        ins_data_i,
    output logic                   ins_ack_o,
    output logic                   wb_req_o,
    output logic [`REG_ADDR_W-1:0] wb_rd_o,
    output logic [`XLEN-1:0]       wb_data_o,
    input  wire                    wb_ack_i
);

    rv_int_pipe_pkg::decoded_op_t dec_op;
    rv_int_pipe_pkg::decoded_op_t dec_head;
    logic                         dec_push;
    logic                         dec_pop;
    logic                         dec_empty;
    logic                         dec_full;

    rv_int_pipe_pkg::retire_t     ret_rec;
    rv_int_pipe_pkg::retire_t     ret_head;
    logic                         ret_push;
    logic                         ret_pop;
    logic                         ret_empty;
    logic                         ret_full;

    insn_decoder u_insn_decoder (
        .c_clk      (c_clk      ),
        .c_rst_n    (c_rst_n    ),
        .ins_req_i  (ins_req_i  ),
        .ins_data_i (ins_data_i ),
        .ins_ack_o  (ins_ack_o  ),
        .full_i     (dec_full   ),
        .push_o     (dec_push   ),
        .op_o       (dec_op     )
    );

    stage_fifo #(
        .payload_t  (rv_int_pipe_pkg::decoded_op_t),
        .DEPTH      (`FIFO_DEPTH)
    ) u_dec_fifo (
        .c_clk      (c_clk      ),
        .c_rst_n    (c_rst_n    ),
        .push_i     (dec_push   ),
        .data_i     (dec_op     ),
        .pop_i      (dec_pop    ),
        .head_o     (dec_head   ),
        .empty_o    (dec_empty  ),
        .full_o     (dec_full   )
    );

    alu_exec u_alu_exec (
        .c_clk      (c_clk      ),
        .c_rst_n    (c_rst_n    ),
        .op_i       (dec_head   ),
        .op_empty_i (dec_empty  ),
        .op_pop_o   (dec_pop    ),
        .ret_full_i (ret_full   ),
        .ret_push_o (ret_push   ),
        .ret_o      (ret_rec    )
    );

    stage_fifo #(
        .payload_t  (rv_int_pipe_pkg::retire_t),
        .DEPTH      (`FIFO_DEPTH)
    ) u_ret_fifo (
        .c_clk      (c_clk      ),
        .c_rst_n    (c_rst_n    ),
        .push_i     (ret_push   ),
        .data_i     (ret_rec    ),
        .pop_i      (ret_pop    ),
        .head_o     (ret_head   ),
        .empty_o    (ret_empty  ),
        .full_o     (ret_full   )
    );

    retire_port u_retire_port (
        .c_clk      (c_clk      ),
        .c_rst_n    (c_rst_n    ),
        .empty_i    (ret_empty  ),
        .rec_i      (ret_head   ),
        .pop_o      (ret_pop    ),
        .wb_req_o   (wb_req_o   ),
        .wb_rd_o    (wb_rd_o    ),
        .wb_data_o  (wb_data_o  ),
        .wb_ack_i   (wb_ack_i   )
    );

endmodule

`default_nettype wire

// ==== verilog/retire_port.sv ====
//////////////////////////////
// retire port
// four-phase sender of
// retire records
//////////////////////////////

`timescale 1ns/1ps
`default_nettype none

`include "rv_int_pipe_consts.svh"

module retire_port (
    input  wire                      c_clk,
    input  wire                      c_rst_n,
    input  wire                      empty_i,
    input  rv_int_pipe_pkg::retire_t rec_i,
    output logic                     pop_o,
    output logic                     wb_req_o,
    output logic [`REG_ADDR_W-1:0]   wb_rd_o,
    output logic [`XLEN-1:0]         wb_data_o,
    input  wire                      wb_ack_i
);

    typedef enum logic [1:0] {
        S_IDLE,
        S_WAIT_HI,
        S_WAIT_LO
    } state_t;

    state_t                   state;
    rv_int_pipe_pkg::retire_t hold;

    assign pop_o     = (state == S_IDLE) && !empty_i;
    assign wb_req_o  = (state == S_WAIT_HI);
    assign wb_rd_o   = hold.rd;
    assign wb_data_o = hold.data;

    always_ff @(posedge c_clk) begin
        if (pop_o) begin
            hold <= rec_i;
        end
    end

    always_ff @(posedge c_clk) begin
        if (!c_rst_n) begin
            state <= S_IDLE;
        end else begin
            case (state)
                S_IDLE:    if (!empty_i) state <= S_WAIT_HI;
                S_WAIT_HI: if (wb_ack_i) state <= S_WAIT_LO;
                // next record only once ack is back low
                S_WAIT_LO: if (!wb_ack_i) state <= S_IDLE;
                default:   state <= S_IDLE;
            endcase
        end
    end

    // req only drops while the receiver is answering it
    a_req_held: assert property (@(posedge c_clk) disable iff (!c_rst_n)
        $fell(wb_req_o) |-> wb_ack_i);

endmodule

`default_nettype wire

// ==== verilog/alu_exec.sv ====
//////////////////////////////
// execute stage
// register file, ALU and
// retire record forming
//////////////////////////////

`timescale 1ns/1ps
`default_nettype none

`include "rv_int_pipe_consts.svh"

module alu_exec (
    input  wire                          c_clk,
    input  wire                          c_rst_n,
    input  rv_int_pipe_pkg::decoded_op_t op_i,
    input  wire                          op_empty_i,
    output logic                         op_pop_o,
    input  wire                          ret_full_i,
    output logic                         ret_push_o,
    output rv_int_pipe_pkg::retire_t     ret_o
);

    // x1..x31, x0 is hardwired in the read mux
    logic [`XLEN-1:0] regs [1:31];

    logic             issue;
    logic [`XLEN-1:0] rs1_data;
    logic [`XLEN-1:0] rs2_data;
    logic [`XLEN-1:0] alu_a;
    logic [`XLEN-1:0] alu_b;
    logic [5:0]       shamt;
    logic [`XLEN-1:0] alu_out;

    function automatic logic [`XLEN-1:0] rf_read(input logic [`REG_ADDR_W-1:0] idx);
        logic [`XLEN-1:0] val;
        val = '0;
        if (idx != '0) begin
            val = regs[idx];
        end
        return val;
    endfunction

    // one op per cycle whenever both sides allow it
    assign issue      = !op_empty_i && !ret_full_i;
    assign op_pop_o   = issue;
    assign ret_push_o = issue;

    assign rs1_data = rf_read(op_i.rs1);
    assign rs2_data = rf_read(op_i.rs2);

    assign alu_a = op_i.use_zero_a ? '0 : rs1_data;
    assign alu_b = op_i.use_imm ? op_i.imm : rs2_data;
    assign shamt = alu_b[5:0];

    always_comb begin
        case (op_i.alu_fn)
            rv_int_pipe_pkg::ALU_ADD:  alu_out = alu_a + alu_b;
            rv_int_pipe_pkg::ALU_SUB:  alu_out = alu_a - alu_b;
            rv_int_pipe_pkg::ALU_SLL:  alu_out = alu_a << shamt;
            rv_int_pipe_pkg::ALU_SLT:
                alu_out = {{(`XLEN-1){1'b0}}, $signed(alu_a) < $signed(alu_b)};
            rv_int_pipe_pkg::ALU_SLTU:
                alu_out = {{(`XLEN-1){1'b0}}, alu_a < alu_b};
            rv_int_pipe_pkg::ALU_XOR:  alu_out = alu_a ^ alu_b;
            rv_int_pipe_pkg::ALU_SRL:  alu_out = alu_a >> shamt;
            rv_int_pipe_pkg::ALU_SRA:  alu_out = $unsigned($signed(alu_a) >>> shamt);
            rv_int_pipe_pkg::ALU_OR:   alu_out = alu_a | alu_b;
            rv_int_pipe_pkg::ALU_AND:  alu_out = alu_a & alu_b;
            default:                   alu_out = '0;
        endcase
    end

    // writes to x0 retire as zero
    assign ret_o.rd   = op_i.rd;
    assign ret_o.data = (op_i.rd == '0) ? '0 : alu_out;

    always_ff @(posedge c_clk) begin
        if (!c_rst_n) begin
            for (int i = 1; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (issue && (op_i.rd != '0)) begin
            regs[op_i.rd] <= alu_out;
        end
    end

    // every pushed record has all bits known
    a_push_known: assert property (@(posedge c_clk) disable iff (!c_rst_n)
        ret_push_o |-> !$isunknown(ret_o));

endmodule

`default_nettype wire

// ==== verilog/stage_fifo.sv ====
//////////////////////////////
// stage FIFO
// small circular buffer for
// any packed payload type
//////////////////////////////

`timescale 1ns/1ps
`default_nettype none

`include "rv_int_pipe_consts.svh"

module stage_fifo #(
    parameter type payload_t = logic,
    parameter int  DEPTH     = `FIFO_DEPTH
) (
    input  wire      c_clk,
    input  wire      c_rst_n,
    input  wire      push_i,
    input  payload_t data_i,
    input  wire      pop_i,
    output payload_t head_o,
    output logic     empty_o,
    output logic     full_o
);

    localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CNT_W = $clog2(DEPTH + 1);

    payload_t         mem [0:DEPTH-1];
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [CNT_W-1:0] count;

    assign head_o  = mem[rd_ptr];
    assign empty_o = (count == '0);
    assign full_o  = (count == CNT_W'(DEPTH));

    always_ff @(posedge c_clk) begin
        if (push_i) begin
            mem[wr_ptr] <= data_i;
        end
    end

    always_ff @(posedge c_clk) begin
        if (!c_rst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push_i) begin
                wr_ptr <= (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (pop_i) begin
                rd_ptr <= (rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            end
            // simultaneous push and pop leaves the count alone
            case ({push_i, pop_i})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    a_no_overflow: assert property (@(posedge c_clk) disable iff (!c_rst_n)
        push_i |-> !full_o);
    a_no_underflow: assert property (@(posedge c_clk) disable iff (!c_rst_n)
        pop_i |-> !empty_o);

endmodule

`default_nettype wire

// ==== verilog/insn_decoder.sv ====
//////////////////////////////
// instruction decoder
// four-phase receiver, field
// split and immediate mux
//////////////////////////////

`timescale 1ns/1ps
`default_nettype none

`include "rv_int_pipe_consts.svh"

module insn_decoder (
    input  wire                          c_clk,
    input  wire                          c_rst_n,
    input  wire                          ins_req_i,
    input  wire [`ILEN-1:0]              ins_data_i,
    output logic                         ins_ack_o,
    input  wire                          full_i,
    output logic                         push_o,
    output rv_int_pipe_pkg::decoded_op_t op_o
);

    logic [6:0] opcode;
    logic [2:0] funct3;
    logic       is_alri;
    logic       is_alrr;
    logic       is_lui;
    logic       capture;

    assign opcode  = ins_data_i[6:0];
    assign funct3  = ins_data_i[14:12];
    assign is_alri = (opcode == `OP_ALRI);
    assign is_alrr = (opcode == `OP_ALRR);
    assign is_lui  = (opcode == `OP_LUI);

    // take a word only once per request and only with room downstream
    assign capture = ins_req_i && !ins_ack_o && !full_i;
    // unknown opcodes are acked but never pushed
    assign push_o  = capture && (is_alri || is_alrr || is_lui);

    always_ff @(posedge c_clk) begin
        if (!c_rst_n) begin
            ins_ack_o <= 1'b0;
        end else if (capture) begin
            ins_ack_o <= 1'b1;
        end else if (ins_ack_o && !ins_req_i) begin
            ins_ack_o <= 1'b0;
        end
    end

    always_comb begin
        op_o.rs1        = ins_data_i[19:15];
        op_o.rs2        = ins_data_i[24:20];
        op_o.rd         = ins_data_i[11:7];
        op_o.use_imm    = is_alri || is_lui;
        op_o.use_zero_a = is_lui;

        // I-type for OP-IMM, shifts only look at bits 25:20 of it
        if (is_lui) begin
            op_o.imm = {{(`XLEN-32){ins_data_i[31]}}, ins_data_i[31:12], 12'b0};
        end else if (is_alri) begin
            op_o.imm = {{(`XLEN-12){ins_data_i[31]}}, ins_data_i[31:20]};
        end else begin
            op_o.imm = '0;
        end

        case (funct3)
            3'b000:  op_o.alu_fn = (is_alrr && ins_data_i[30]) ? rv_int_pipe_pkg::ALU_SUB
                                                                : rv_int_pipe_pkg::ALU_ADD;
            3'b001:  op_o.alu_fn = rv_int_pipe_pkg::ALU_SLL;
            3'b010:  op_o.alu_fn = rv_int_pipe_pkg::ALU_SLT;
            3'b011:  op_o.alu_fn = rv_int_pipe_pkg::ALU_SLTU;
            3'b100:  op_o.alu_fn = rv_int_pipe_pkg::ALU_XOR;
            3'b101:  op_o.alu_fn = ins_data_i[30] ? rv_int_pipe_pkg::ALU_SRA
                                                  : rv_int_pipe_pkg::ALU_SRL;
            3'b110:  op_o.alu_fn = rv_int_pipe_pkg::ALU_OR;
            default: op_o.alu_fn = rv_int_pipe_pkg::ALU_AND;
        endcase
        if (is_lui) begin
            op_o.alu_fn = rv_int_pipe_pkg::ALU_ADD;
        end
    end

    // ack only answers a request the sender is still holding
    a_ack_after_req: assert property (@(posedge c_clk) disable iff (!c_rst_n)
        $rose(ins_ack_o) |-> ins_req_i);

endmodule

`default_nettype wire

// ==== verilog/rv_int_pipe_pkg.sv ====
//////////////////////////////
// rv_int_pipe types
// ALU functions, decoded ops
// and retire records
//////////////////////////////

`default_nettype none

`include "rv_int_pipe_consts.svh"

package rv_int_pipe_pkg;

    // encoded as {insn[30], funct3}
    typedef enum logic [3:0] {
        ALU_ADD  = 4'b0000,
        ALU_SUB  = 4'b1000,
        ALU_SLL  = 4'b0001,
        ALU_SLT  = 4'b0010,
        ALU_SLTU = 4'b0011,
        ALU_XOR  = 4'b0100,
        ALU_SRL  = 4'b0101,
        ALU_SRA  = 4'b1101,
        ALU_OR   = 4'b0110,
        ALU_AND  = 4'b0111
    } alu_fn_t;

    typedef struct packed {
        alu_fn_t                alu_fn;
        logic [`REG_ADDR_W-1:0] rs1;
        logic [`REG_ADDR_W-1:0] rs2;
        logic [`REG_ADDR_W-1:0] rd;
        logic                   use_imm;
        logic                   use_zero_a;  // LUI: 0 + imm
        logic [`XLEN-1:0]       imm;
    } decoded_op_t;

    typedef struct packed {
        logic [`REG_ADDR_W-1:0] rd;
        logic [`XLEN-1:0]       data;
    } retire_t;

endpackage

`default_nettype wire

// ==== verilog/rv_int_pipe_consts.svh ====
//////////////////////////////
// rv_int_pipe constants
// widths, kept opcodes and the
// default stage FIFO depth
//////////////////////////////

`ifndef RV_INT_PIPE_CONSTS_SVH
`define RV_INT_PIPE_CONSTS_SVH

// datapath and instruction widths
`define XLEN        64
`define ILEN        32
`define REG_ADDR_W  5

// entries per stage FIFO
`define FIFO_DEPTH  2

// major opcodes that retire
`define OP_ALRI     7'b0010011
`define OP_ALRR     7'b0110011
`define OP_LUI      7'b0110111

`endif
